/* rtl/cache_cfg_pkg.sv */
// L1 data cache geometry
// Sizes of the cache and the address fields derived from them
package cache_cfg_pkg;

	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 8;
	localparam int LINE_BYTES = 8;

	// Address split is offset, then set index, then tag
	localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
	localparam int SET_INDEX_WIDTH = $clog2(NUM_SETS);
	localparam int TAG_WIDTH = 32 - OFFSET_WIDTH - SET_INDEX_WIDTH;
	localparam int WAY_INDEX_WIDTH = $clog2(NUM_WAYS);

	// Address bits 3 to 5
	typedef logic [SET_INDEX_WIDTH-1:0] set_index_t;

	// Address bits 6 to 31
	typedef logic [TAG_WIDTH-1:0] cache_tag_t;

	typedef logic [WAY_INDEX_WIDTH-1:0] way_index_t;

	// One full line, 64 bits
	typedef logic [LINE_BYTES*8-1:0] line_data_t;

endpackage

/* rtl/cache_lru.sv */
// True LRU replacement, one age order per set
// Position 0 holds the oldest way and the last position the newest
`timescale 1ns/10ps

module cache_lru
(
	input logic clk,
	input logic rst_i,
	input cache_cfg_pkg::set_index_t set_i,
	input logic update_i,
	input cache_cfg_pkg::way_index_t mru_way_i,
	output cache_cfg_pkg::way_index_t lru_way_o
);

	localparam int LAST = cache_cfg_pkg::NUM_WAYS - 1;

	cache_cfg_pkg::way_index_t age_order [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
	cache_cfg_pkg::way_index_t cur_order [cache_cfg_pkg::NUM_WAYS];
	cache_cfg_pkg::way_index_t next_order [cache_cfg_pkg::NUM_WAYS];
	cache_cfg_pkg::way_index_t mru_pos;

	// Everything newer than the touched way slides one step toward the old end
	always_comb
	begin
		mru_pos = '0;
		for (int i = 0; i < cache_cfg_pkg::NUM_WAYS; i++)
		begin
			cur_order[i] = age_order[set_i][i];
			if (age_order[set_i][i] == mru_way_i)
				mru_pos = cache_cfg_pkg::way_index_t'(i);
		end
		for (int i = 0; i < LAST; i++)
		begin
			if (i >= int'(mru_pos))
				next_order[i] = cur_order[i + 1];
			else
				next_order[i] = cur_order[i];
		end
		next_order[LAST] = mru_way_i;
	end

	assign lru_way_o = cur_order[0];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int s = 0; s < cache_cfg_pkg::NUM_SETS; s++)
				for (int i = 0; i < cache_cfg_pkg::NUM_WAYS; i++)
					age_order[s][i] <= cache_cfg_pkg::way_index_t'(i);
		end
		else if (update_i)
		begin
			for (int i = 0; i < cache_cfg_pkg::NUM_WAYS; i++)
				age_order[set_i][i] <= next_order[i];
		end
	end

endmodule

/* rtl/cache_tag_mem.sv */
// Tag and valid storage for the four ways
// Reads all ways at the edge and compares them in the following cycle
`timescale 1ns/10ps

module cache_tag_mem
(
	input logic clk,
	input logic rst_i,
	input logic access_i,
	input cache_cfg_pkg::set_index_t set_i,
	input cache_cfg_pkg::cache_tag_t tag_i,
	fill_if.sink fill,
	output logic cache_hit_o,
	output cache_cfg_pkg::way_index_t hit_way_o
);

	cache_cfg_pkg::cache_tag_t tag_array [cache_cfg_pkg::NUM_WAYS][cache_cfg_pkg::NUM_SETS];
	logic [cache_cfg_pkg::NUM_SETS-1:0] valid_bits [cache_cfg_pkg::NUM_WAYS];

	logic access_latched;
	cache_cfg_pkg::cache_tag_t tag_latched;
	cache_cfg_pkg::cache_tag_t tag_read [cache_cfg_pkg::NUM_WAYS];
	logic [cache_cfg_pkg::NUM_WAYS-1:0] valid_read;

	// A fill sets the valid bit of its way
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++)
				valid_bits[w] <= '0;
			valid_read <= '0;
			access_latched <= 1'b0;
		end
		else
		begin
			if (fill.valid)
				valid_bits[fill.way][fill.set] <= 1'b1;
			for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++)
				valid_read[w] <= valid_bits[w][set_i];
			access_latched <= access_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill.valid)
			tag_array[fill.way][fill.set] <= fill.tag;
		for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++)
			tag_read[w] <= tag_array[w][set_i];
		tag_latched <= tag_i;
	end

	// At most one way can hold a given line, so the order of the scan does not matter
	always_comb
	begin
		cache_hit_o = 1'b0;
		hit_way_o = '0;
		for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++)
		begin
			if (access_latched && valid_read[w] && tag_read[w] == tag_latched)
			begin
				cache_hit_o = 1'b1;
				hit_way_o = cache_cfg_pkg::way_index_t'(w);
			end
		end
	end

endmodule

/* rtl/fill_if.sv */
// Line fill bus from the miss queue to the tag and data arrays
`timescale 1ns/10ps

interface fill_if;

	logic valid;
	cache_cfg_pkg::way_index_t way;
	cache_cfg_pkg::set_index_t set;
	cache_cfg_pkg::cache_tag_t tag;
	cache_cfg_pkg::line_data_t data;

	// Miss queue side
	modport source (output valid, way, set, tag, data);

	// Tag memory and data ways
	modport sink (input valid, way, set, tag, data);

endinterface

/* rtl/l1_cache.sv */
// L1 data cache, four ways, virtually indexed and tagged, non-blocking
// Tags and all data ways are read in parallel with one cycle of latency
`timescale 1ns/10ps

module l1_cache
(
	input logic clk,
	input logic rst_i,
	input logic access_i,
	input l2_bus_pkg::strand_t strand_i,
	input logic [31:0] address_i,
	output cache_cfg_pkg::line_data_t data_o,
	output logic cache_hit_o,
	output logic load_collision_o,
	output l2_bus_pkg::strand_mask_t load_complete_o,
	output logic l2_req_valid_o,
	output l2_bus_pkg::l2_op_t l2_req_op_o,
	output l2_bus_pkg::strand_t l2_req_strand_o,
	output l2_bus_pkg::line_address_t l2_req_address_o,
	input logic l2_req_ack_i,
	input logic l2_resp_valid_i,
	input l2_bus_pkg::strand_t l2_resp_strand_i,
	input cache_cfg_pkg::line_data_t l2_resp_data_i
);

	localparam int SET_LSB = cache_cfg_pkg::OFFSET_WIDTH;
	localparam int TAG_LSB = cache_cfg_pkg::OFFSET_WIDTH + cache_cfg_pkg::SET_INDEX_WIDTH;

	cache_cfg_pkg::set_index_t requested_set;
	cache_cfg_pkg::cache_tag_t requested_tag;
	logic access_latched;
	l2_bus_pkg::strand_t strand_latched;
	cache_cfg_pkg::set_index_t set_latched;
	cache_cfg_pkg::cache_tag_t tag_latched;

	cache_cfg_pkg::line_data_t way_data [cache_cfg_pkg::NUM_WAYS][cache_cfg_pkg::NUM_SETS];
	cache_cfg_pkg::line_data_t way_read [cache_cfg_pkg::NUM_WAYS];
	cache_cfg_pkg::way_index_t hit_way;
	cache_cfg_pkg::way_index_t lru_way;

	l2_bus_pkg::strand_mask_t pending;
	l2_bus_pkg::line_address_t pending_line [l2_bus_pkg::NUM_STRANDS];
	logic fill_collision_q;
	logic fill_collision_now;
	logic pending_match;
	logic queue_miss;

	fill_if fill_bus ();

	assign requested_set = address_i[SET_LSB +: cache_cfg_pkg::SET_INDEX_WIDTH];
	assign requested_tag = address_i[TAG_LSB +: cache_cfg_pkg::TAG_WIDTH];

	cache_tag_mem tag_mem
	(
		.clk(clk),
		.rst_i(rst_i),
		.access_i(access_i),
		.set_i(requested_set),
		.tag_i(requested_tag),
		.fill(fill_bus.sink),
		.cache_hit_o(cache_hit_o),
		.hit_way_o(hit_way)
	);

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			access_latched <= 1'b0;
			fill_collision_q <= 1'b0;
		end
		else
		begin
			access_latched <= access_i;
			// The tag read at this edge misses a line that is written at the same edge
			fill_collision_q <= access_i && fill_bus.valid && fill_bus.set == requested_set
				&& fill_bus.tag == requested_tag;
		end
	end

	always_ff @(posedge clk)
	begin
		strand_latched <= strand_i;
		set_latched <= requested_set;
		tag_latched <= requested_tag;
		if (queue_miss)
			pending_line[strand_latched] <= {tag_latched, set_latched};
	end

	// Data ways, written by fills and read in parallel for every lookup
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++)
		begin
			if (fill_bus.valid && fill_bus.way == cache_cfg_pkg::way_index_t'(w))
				way_data[w][fill_bus.set] <= fill_bus.data;
			way_read[w] <= way_data[w][requested_set];
		end
	end

	assign data_o = way_read[hit_way];

	// Another strand already waits for this line
	always_comb
	begin
		pending_match = 1'b0;
		for (int s = 0; s < l2_bus_pkg::NUM_STRANDS; s++)
		begin
			if (pending[s] && l2_bus_pkg::strand_t'(s) != strand_latched
				&& pending_line[s] == {tag_latched, set_latched})
				pending_match = 1'b1;
		end
	end

	assign fill_collision_now = fill_bus.valid && fill_bus.set == set_latched
		&& fill_bus.tag == tag_latched;
	assign load_collision_o = access_latched && !cache_hit_o
		&& (fill_collision_now || fill_collision_q || pending_match);
	assign queue_miss = access_latched && !cache_hit_o && !load_collision_o;

	// The victim is made MRU at once so a second miss in the set picks another way
	cache_lru lru
	(
		.clk(clk),
		.rst_i(rst_i),
		.set_i(set_latched),
		.update_i(cache_hit_o || queue_miss),
		.mru_way_i(cache_hit_o ? hit_way : lru_way),
		.lru_way_o(lru_way)
	);

	load_miss_queue miss_queue
	(
		.clk(clk),
		.rst_i(rst_i),
		.request_i(queue_miss),
		.strand_i(strand_latched),
		.set_i(set_latched),
		.tag_i(tag_latched),
		.victim_way_i(lru_way),
		.fill(fill_bus.source),
		.pending_o(pending),
		.load_complete_o(load_complete_o),
		.l2_req_valid_o(l2_req_valid_o),
		.l2_req_op_o(l2_req_op_o),
		.l2_req_strand_o(l2_req_strand_o),
		.l2_req_address_o(l2_req_address_o),
		.l2_req_ack_i(l2_req_ack_i),
		.l2_resp_valid_i(l2_resp_valid_i),
		.l2_resp_strand_i(l2_resp_strand_i),
		.l2_resp_data_i(l2_resp_data_i)
	);

endmodule

/* rtl/l2_bus_pkg.sv */
// L2 request and response definitions
// Strand numbering and the line address carried to the L2
package l2_bus_pkg;

	localparam int NUM_STRANDS = 4;

	typedef logic [$clog2(NUM_STRANDS)-1:0] strand_t;

	// One bit per strand, used for pending and wake masks
	typedef logic [NUM_STRANDS-1:0] strand_mask_t;

	// Tag and set joined, the line offset is dropped
	typedef logic [cache_cfg_pkg::TAG_WIDTH + cache_cfg_pkg::SET_INDEX_WIDTH - 1:0]
		line_address_t;

	// Only line loads are issued by this cache
	typedef enum logic [1:0]
	{
		L2_OP_LOAD_LINE = 2'd0
	} l2_op_t;

endpackage

/* rtl/load_miss_queue.sv */
// Pending load misses, one entry per strand
// Issues line requests to the L2 and turns responses into line fills
`timescale 1ns/10ps

module load_miss_queue
(
	input logic clk,
	input logic rst_i,
	input logic request_i,
	input l2_bus_pkg::strand_t strand_i,
	input cache_cfg_pkg::set_index_t set_i,
	input cache_cfg_pkg::cache_tag_t tag_i,
	input cache_cfg_pkg::way_index_t victim_way_i,
	fill_if.source fill,
	output l2_bus_pkg::strand_mask_t pending_o,
	output l2_bus_pkg::strand_mask_t load_complete_o,
	output logic l2_req_valid_o,
	output l2_bus_pkg::l2_op_t l2_req_op_o,
	output l2_bus_pkg::strand_t l2_req_strand_o,
	output l2_bus_pkg::line_address_t l2_req_address_o,
	input logic l2_req_ack_i,
	input logic l2_resp_valid_i,
	input l2_bus_pkg::strand_t l2_resp_strand_i,
	input cache_cfg_pkg::line_data_t l2_resp_data_i
);

	l2_bus_pkg::strand_mask_t entry_valid;
	l2_bus_pkg::strand_mask_t entry_issued;
	cache_cfg_pkg::set_index_t entry_set [l2_bus_pkg::NUM_STRANDS];
	cache_cfg_pkg::cache_tag_t entry_tag [l2_bus_pkg::NUM_STRANDS];
	cache_cfg_pkg::way_index_t entry_way [l2_bus_pkg::NUM_STRANDS];

	logic req_valid_q;
	l2_bus_pkg::strand_t req_strand_q;
	l2_bus_pkg::strand_t rr_ptr;
	l2_bus_pkg::strand_mask_t candidates;
	l2_bus_pkg::strand_mask_t fill_mask;
	logic pick_found;
	l2_bus_pkg::strand_t pick_strand;

	// A miss arriving this cycle may be picked right away
	always_comb
	begin
		l2_bus_pkg::strand_t probe;
		candidates = entry_valid & ~entry_issued;
		if (request_i)
			candidates[strand_i] = 1'b1;
		pick_found = 1'b0;
		pick_strand = rr_ptr;
		for (int i = 0; i < l2_bus_pkg::NUM_STRANDS; i++)
		begin
			probe = rr_ptr + l2_bus_pkg::strand_t'(i);
			if (!pick_found && candidates[probe])
			begin
				pick_found = 1'b1;
				pick_strand = probe;
			end
		end
	end

	assign fill_mask = l2_resp_valid_i ? l2_bus_pkg::strand_mask_t'(1) << l2_resp_strand_i : '0;

	// The issued flag is set once an entry is loaded into the request register
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			entry_valid <= '0;
			entry_issued <= '0;
			req_valid_q <= 1'b0;
			req_strand_q <= '0;
			rr_ptr <= '0;
			load_complete_o <= '0;
		end
		else
		begin
			load_complete_o <= fill_mask;
			if (request_i)
			begin
				entry_valid[strand_i] <= 1'b1;
				entry_issued[strand_i] <= 1'b0;
			end
			if (l2_resp_valid_i)
				entry_valid[l2_resp_strand_i] <= 1'b0;
			if (!req_valid_q || l2_req_ack_i)
			begin
				req_valid_q <= pick_found;
				if (pick_found)
				begin
					req_strand_q <= pick_strand;
					entry_issued[pick_strand] <= 1'b1;
					rr_ptr <= pick_strand + l2_bus_pkg::strand_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (request_i)
		begin
			entry_set[strand_i] <= set_i;
			entry_tag[strand_i] <= tag_i;
			entry_way[strand_i] <= victim_way_i;
		end
	end

	// Fields come from the entry table and stay put until the response clears it
	assign l2_req_valid_o = req_valid_q;
	assign l2_req_op_o = l2_bus_pkg::L2_OP_LOAD_LINE;
	assign l2_req_strand_o = req_strand_q;
	assign l2_req_address_o = {entry_tag[req_strand_q], entry_set[req_strand_q]};

	assign pending_o = entry_valid;

	assign fill.valid = l2_resp_valid_i;
	assign fill.way = entry_way[l2_resp_strand_i];
	assign fill.set = entry_set[l2_resp_strand_i];
	assign fill.tag = entry_tag[l2_resp_strand_i];
	assign fill.data = l2_resp_data_i;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the L1 cache testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sim.f --top-module l1_cache_tb -o l1_cache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/l1_cache_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification passed" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

/* sim.f */
rtl/cache_cfg_pkg.sv
rtl/l2_bus_pkg.sv
rtl/fill_if.sv
rtl/cache_tag_mem.sv
rtl/cache_lru.sv
rtl/load_miss_queue.sv
rtl/l1_cache.sv
test/l1_cache_checker.sv
test/l1_cache_tb.sv

/* test/l1_cache_checker.sv */
// Protocol checks on the load miss queue and its L2 request channel
`timescale 1ns/10ps

module l1_cache_checker
(
	input logic clk,
	input logic rst_i,
	input logic request_i,
	input l2_bus_pkg::strand_t strand_i,
	input l2_bus_pkg::strand_mask_t pending_o,
	input logic l2_req_valid_o,
	input l2_bus_pkg::strand_t l2_req_strand_o,
	input l2_bus_pkg::line_address_t l2_req_address_o,
	input logic l2_req_ack_i,
	input logic l2_resp_valid_i,
	input l2_bus_pkg::strand_t l2_resp_strand_i
);

	// A request that is not taken keeps its fields
	held_request: assert property (@(posedge clk) disable iff (rst_i)
		l2_req_valid_o && !l2_req_ack_i |=> l2_req_valid_o && $stable(l2_req_strand_o)
			&& $stable(l2_req_address_o))
		else $error("L2 request dropped or changed before ack");

	response_pending: assert property (@(posedge clk) disable iff (rst_i)
		l2_resp_valid_i |-> pending_o[l2_resp_strand_i])
		else $error("L2 response for a strand without a pending miss");

	single_miss: assert property (@(posedge clk) disable iff (rst_i)
		request_i |-> !pending_o[strand_i])
		else $error("Second miss queued for a strand that is already pending");

endmodule

bind load_miss_queue l1_cache_checker i_checker
(
	.clk(clk),
	.rst_i(rst_i),
	.request_i(request_i),
	.strand_i(strand_i),
	.pending_o(pending_o),
	.l2_req_valid_o(l2_req_valid_o),
	.l2_req_strand_o(l2_req_strand_o),
	.l2_req_address_o(l2_req_address_o),
	.l2_req_ack_i(l2_req_ack_i),
	.l2_resp_valid_i(l2_resp_valid_i),
	.l2_resp_strand_i(l2_resp_strand_i)
);

/* test/l1_cache_tb.sv */
// Testbench for the four-way L1 data cache
// Applies a table of strand accesses against an L2 model with random ack and response delays
`timescale 1ns/10ps

module l1_cache_tb;

	localparam time CLK_PERIOD = 100ns;
	localparam int NUM_ROWS = 23;

	typedef struct packed
	{
		l2_bus_pkg::strand_t strand;
		logic [31:0] address;
		logic hit;
		logic collision;
		logic ready_wait;
	} access_row_t;

	logic clk;
	logic rst_i;
	logic access_i;
	l2_bus_pkg::strand_t strand_i;
	logic [31:0] address_i;
	cache_cfg_pkg::line_data_t data_o;
	logic cache_hit_o;
	logic load_collision_o;
	l2_bus_pkg::strand_mask_t load_complete_o;
	logic l2_req_valid_o;
	l2_bus_pkg::l2_op_t l2_req_op_o;
	l2_bus_pkg::strand_t l2_req_strand_o;
	l2_bus_pkg::line_address_t l2_req_address_o;
	logic l2_req_ack_i;
	logic l2_resp_valid_i;
	l2_bus_pkg::strand_t l2_resp_strand_i;
	cache_cfg_pkg::line_data_t l2_resp_data_i;

	// Strand, address, hit, collision, wait until no strand is waiting
	access_row_t rows [NUM_ROWS] = '{
		'{2'd0, 32'h0000_1000, 1'b0, 1'b0, 1'b1},
		'{2'd1, 32'h0001_0010, 1'b0, 1'b0, 1'b1},
		'{2'd1, 32'h0002_0010, 1'b0, 1'b0, 1'b1},
		'{2'd1, 32'h0003_0010, 1'b0, 1'b0, 1'b1},
		'{2'd1, 32'h0004_0010, 1'b0, 1'b0, 1'b1},
		'{2'd1, 32'h0001_0010, 1'b1, 1'b0, 1'b1},
		'{2'd1, 32'h0005_0010, 1'b0, 1'b0, 1'b1},
		'{2'd1, 32'h0001_0010, 1'b1, 1'b0, 1'b1},
		'{2'd1, 32'h0003_0010, 1'b1, 1'b0, 1'b1},
		'{2'd1, 32'h0004_0010, 1'b1, 1'b0, 1'b1},
		'{2'd1, 32'h0002_0010, 1'b0, 1'b0, 1'b1},
		'{2'd2, 32'h0010_0028, 1'b0, 1'b0, 1'b1},
		'{2'd3, 32'h0010_002c, 1'b0, 1'b1, 1'b0},
		'{2'd0, 32'h0020_0008, 1'b0, 1'b0, 1'b1},
		'{2'd1, 32'h0030_0018, 1'b0, 1'b0, 1'b0},
		'{2'd2, 32'h0040_0030, 1'b0, 1'b0, 1'b0},
		'{2'd3, 32'h0050_0038, 1'b0, 1'b0, 1'b0},
		'{2'd0, 32'h0021_0020, 1'b0, 1'b0, 1'b0},
		'{2'd1, 32'h0031_0000, 1'b0, 1'b0, 1'b0},
		'{2'd2, 32'h0041_0008, 1'b0, 1'b0, 1'b0},
		'{2'd3, 32'h0051_0038, 1'b0, 1'b0, 1'b0},
		'{2'd0, 32'h0000_1004, 1'b1, 1'b0, 1'b1},
		'{2'd1, 32'h0003_0010, 1'b1, 1'b0, 1'b1}
	};

	int error_count;
	int check_count;
	int test_count;
	int miss_count;
	int request_count;
	int cycle;
	int ack_delay;
	logic [31:0] rng_state;

	// Per-strand state of the expected cache traffic
	l2_bus_pkg::strand_mask_t waiting;
	l2_bus_pkg::strand_mask_t missed;
	l2_bus_pkg::strand_mask_t requested;
	l2_bus_pkg::strand_mask_t in_flight;
	l2_bus_pkg::strand_mask_t follows_owner;
	l2_bus_pkg::strand_t owner [l2_bus_pkg::NUM_STRANDS];
	logic [31:0] retry_address [l2_bus_pkg::NUM_STRANDS];
	l2_bus_pkg::line_address_t miss_line [l2_bus_pkg::NUM_STRANDS];
	int due_cycle [l2_bus_pkg::NUM_STRANDS];
	l2_bus_pkg::strand_t last_resp_strand;
	l2_bus_pkg::strand_t retry_queue [$];

	l1_cache i_l1_cache
	(
		.clk(clk),
		.rst_i(rst_i),
		.access_i(access_i),
		.strand_i(strand_i),
		.address_i(address_i),
		.data_o(data_o),
		.cache_hit_o(cache_hit_o),
		.load_collision_o(load_collision_o),
		.load_complete_o(load_complete_o),
		.l2_req_valid_o(l2_req_valid_o),
		.l2_req_op_o(l2_req_op_o),
		.l2_req_strand_o(l2_req_strand_o),
		.l2_req_address_o(l2_req_address_o),
		.l2_req_ack_i(l2_req_ack_i),
		.l2_resp_valid_i(l2_resp_valid_i),
		.l2_resp_strand_i(l2_resp_strand_i),
		.l2_resp_data_i(l2_resp_data_i)
	);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// The L2 content of a line is a fixed scramble of its line address
	function automatic cache_cfg_pkg::line_data_t model_line(l2_bus_pkg::line_address_t line);
		logic [31:0] base;
		base = 32'(line);
		return {base * 32'h9e37_79b1, ~base ^ 32'h5bd1_e995};
	endfunction

	task automatic check_line(string name, cache_cfg_pkg::line_data_t got,
		cache_cfg_pkg::line_data_t expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_flag(string name, logic got, logic expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_strand(string name, l2_bus_pkg::strand_t got,
		l2_bus_pkg::strand_t expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_address(string name, l2_bus_pkg::line_address_t got,
		l2_bus_pkg::line_address_t expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
		end
	endtask

	// Starts just after a rising edge and returns once the lookup result is checked
	task automatic run_access(l2_bus_pkg::strand_t strand, logic [31:0] address, logic exp_hit,
		logic exp_collision);
		int errors_before;
		l2_bus_pkg::line_address_t line;
		l2_bus_pkg::strand_t s;
		errors_before = error_count;
		line = address[31:cache_cfg_pkg::OFFSET_WIDTH];
		test_count++;
		access_i = 1'b1;
		strand_i = strand;
		address_i = address;
		@(posedge clk);
		#5;
		access_i = 1'b0;
		@(negedge clk);
		check_flag("cache_hit_o", cache_hit_o, exp_hit);
		check_flag("load_collision_o", load_collision_o, exp_collision);
		retry_address[strand] = address;
		if (exp_hit)
			check_line("data_o", data_o, model_line(line));
		else if (exp_collision)
		begin
			// The strand sleeps until the owner of the line is woken
			waiting[strand] = 1'b1;
			follows_owner[strand] = 1'b0;
			for (int i = 0; i < l2_bus_pkg::NUM_STRANDS; i++)
			begin
				s = l2_bus_pkg::strand_t'(i);
				if (missed[s] && miss_line[s] == line)
				begin
					follows_owner[strand] = 1'b1;
					owner[strand] = s;
				end
			end
			if (!follows_owner[strand])
			begin
				waiting[strand] = 1'b0;
				retry_queue.push_back(strand);
			end
		end
		else
		begin
			miss_count++;
			waiting[strand] = 1'b1;
			missed[strand] = 1'b1;
			requested[strand] = 1'b0;
			miss_line[strand] = line;
		end
		$display("Test %0d strand %0d address %h %s", test_count, strand, address,
			error_count == errors_before ? "ok" : "wrong");
	endtask

	// Wakes the completed strand and every strand that collided on its line
	task automatic release_strand(l2_bus_pkg::strand_t owner_strand);
		l2_bus_pkg::strand_t t;
		check_flag("completion of an issued miss", missed[owner_strand] && requested[owner_strand],
			1'b1);
		check_strand("load_complete_o strand", owner_strand, last_resp_strand);
		waiting[owner_strand] = 1'b0;
		missed[owner_strand] = 1'b0;
		retry_queue.push_back(owner_strand);
		for (int i = 0; i < l2_bus_pkg::NUM_STRANDS; i++)
		begin
			t = l2_bus_pkg::strand_t'(i);
			if (follows_owner[t] && owner[t] == owner_strand)
			begin
				follows_owner[t] = 1'b0;
				waiting[t] = 1'b0;
				retry_queue.push_back(t);
			end
		end
	endtask

	// Called in the cycle before the edge that takes the request
	task automatic accept_request();
		l2_bus_pkg::strand_t s;
		s = l2_req_strand_o;
		request_count++;
		check_flag("L2 request for an open miss", missed[s] && !requested[s], 1'b1);
		check_address("l2_req_address_o", l2_req_address_o, miss_line[s]);
		check_flag("l2_req_op_o is a line load", l2_req_op_o == l2_bus_pkg::L2_OP_LOAD_LINE,
			1'b1);
		requested[s] = 1'b1;
		in_flight[s] = 1'b1;
		due_cycle[s] = cycle + 2 + int'(next_random() % 5);
	endtask

	// Responds to one due request per cycle, starting the search at a random strand
	task automatic send_response();
		int start;
		l2_bus_pkg::strand_t s;
		l2_resp_valid_i = 1'b0;
		start = int'(next_random() % 4);
		for (int i = 0; i < l2_bus_pkg::NUM_STRANDS; i++)
		begin
			s = l2_bus_pkg::strand_t'(start + i);
			if (!l2_resp_valid_i && in_flight[s] && cycle >= due_cycle[s])
			begin
				l2_resp_valid_i = 1'b1;
				l2_resp_strand_i = s;
				l2_resp_data_i = model_line(miss_line[s]);
				in_flight[s] = 1'b0;
				last_resp_strand = s;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// L2 model
	initial
	begin
		logic taken;
		forever
		begin
			@(negedge clk);
			taken = l2_req_valid_o && l2_req_ack_i;
			if (taken)
				accept_request();
			@(posedge clk);
			#5;
			cycle++;
			if (taken)
				l2_req_ack_i = 1'b0;
			else if (l2_req_valid_o && !l2_req_ack_i)
			begin
				if (ack_delay < 0)
					ack_delay = int'(next_random() % 4);
				if (ack_delay == 0)
				begin
					l2_req_ack_i = 1'b1;
					ack_delay = -1;
				end
				else
					ack_delay--;
			end
			send_response();
		end
	end

	// Completion monitor, sampled just after the edge that updates the wake mask
	initial
	begin
		forever
		begin
			@(posedge clk);
			#1;
			if (!rst_i && load_complete_o != '0)
			begin
				check_flag("load_complete_o one-hot", $onehot(load_complete_o), 1'b1);
				for (int i = 0; i < l2_bus_pkg::NUM_STRANDS; i++)
					if (load_complete_o[i])
						release_strand(l2_bus_pkg::strand_t'(i));
			end
		end
	end

	initial
	begin
		repeat (NUM_ROWS * 40 + 8) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", NUM_ROWS * 40 + 8);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		int row;
		l2_bus_pkg::strand_t s;
		rng_state = 32'h7b0076f6;
		rst_i = 1'b1;
		access_i = 1'b0;
		strand_i = '0;
		address_i = '0;
		l2_req_ack_i = 1'b0;
		l2_resp_valid_i = 1'b0;
		l2_resp_strand_i = '0;
		l2_resp_data_i = '0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		miss_count = 0;
		request_count = 0;
		cycle = 0;
		ack_delay = -1;
		waiting = '0;
		missed = '0;
		requested = '0;
		in_flight = '0;
		follows_owner = '0;
		last_resp_strand = '0;
		repeat (8) @(posedge clk);
		#5;
		rst_i = 1'b0;
		check_flag("l2_req_valid_o after reset", l2_req_valid_o, 1'b0);
		check_flag("load_complete_o clear after reset", load_complete_o == '0, 1'b1);
		row = 0;
		while (row < NUM_ROWS || retry_queue.size() != 0 || waiting != '0)
		begin
			@(posedge clk);
			#5;
			if (retry_queue.size() != 0)
			begin
				s = retry_queue.pop_front();
				run_access(s, retry_address[s], 1'b1, 1'b0);
			end
			else if (row < NUM_ROWS && !waiting[rows[row].strand]
				&& !(rows[row].ready_wait && waiting != '0))
			begin
				run_access(rows[row].strand, rows[row].address, rows[row].hit,
					rows[row].collision);
				row++;
			end
		end
		check_flag("one L2 request per miss", request_count == miss_count, 1'b1);
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
